// ==== Makefile ====
# Verilator build of the game control testbench
# The binary is rebuilt only when the file list or a listed source changes

obj_dir/VgameMainControlTb: gameMainControl.f $(shell cat gameMainControl.f)
	verilator --binary --timing -Wno-fatal --top-module gameMainControlTb -f gameMainControl.f

# Exit status of the simulator is the test result
run: obj_dir/VgameMainControlTb
	./obj_dir/VgameMainControlTb

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== gameMainControl.f ====
hdl/gamePkg.sv
hdl/boardEventIf.sv
hdl/boardEventDecoder.sv
hdl/levelMenu.sv
hdl/gameSequencer.sv
hdl/screenOutputDecoder.sv
hdl/gameMainControl.sv
verif/gameMainControlTb.sv

// ==== hdl/boardEventDecoder.sv ====
module boardEventDecoder
	import gamePkg::*;
(
	boardEventIf.decoder board,
	output eventKind_t eventKind,
	output eventSlot_u eventSlot,
	output logic [rowWidth-1:0] mergedRow
);

	logic rowFull;

	// Piece merged into the background
	assign mergedRow = board.pointRow | board.backgroundRow;
	assign rowFull = &mergedRow;

	// ============================================================
	// Event classification
	// ============================================================
	always_comb
	begin
		eventKind = evNone;
		eventSlot = '0;
		case (board.crashCode)
			// Piece hit the top
			2'b01:
			begin
				if (board.livesCode == 2'd3 || board.livesCode == 2'd2)
				begin
					eventKind = evCrash;
					eventSlot.livesLeft = board.livesCode;
				end
				else if (board.livesCode == 2'd1)
				begin
					// No lives after this one
					eventKind = evLastCrash;
					eventSlot.livesLeft = board.livesCode;
				end
			end
			// Bonus only counts on the last life
			2'b11:
			begin
				if (board.livesCode == 2'd1)
				begin
					eventKind = evWinLife;
					eventSlot.livesLeft = board.livesCode;
				end
			end
			// Piece landed in the row
			2'b10:
			begin
				if (!rowFull)
					eventKind = evRowFull;
				else if (board.levelCode >= 3'd1 && board.levelCode <= 3'd3)
				begin
					eventKind = evLevelClear;
					eventSlot.levelIndex = board.levelCode[1:0] - 2'd1;
				end
				else if (board.levelCode == 3'd4)
				begin
					// Level 4 wraps to index 3
					eventKind = evGameWon;
					eventSlot.levelIndex = board.levelCode[1:0] - 2'd1;
				end
			end
			default:
				eventKind = evNone;
		endcase
	end

endmodule

// ==== hdl/boardEventIf.sv ====
interface boardEventIf
	import gamePkg::*;
();

	// Status from the game datapath
	logic [statusWidth-1:0] crashCode;
	logic [statusWidth-1:0] livesCode;
	logic [levelWidth-1:0] levelCode;
	// Falling piece row and settled background row
	logic [rowWidth-1:0] pointRow;
	logic [rowWidth-1:0] backgroundRow;

	// Event classification needs everything
	modport decoder (input crashCode, livesCode, levelCode, pointRow, backgroundRow);

	// Output mux only passes the background through
	modport screen (input backgroundRow);

endinterface

// ==== hdl/gameMainControl.sv ====
module gameMainControl
	import gamePkg::*;
(
	input logic SC_STATEMACHINEMAIN_CLOCK_50,
	input logic SC_STATEMACHINEMAIN_RESET_InHigh,
	input logic startButtonLow,
	input logic leftButtonLow,
	input logic rightButtonLow,
	input logic finishLow,
	input logic [statusWidth-1:0] crashCode,
	input logic [rowWidth-1:0] pointRow,
	input logic [rowWidth-1:0] backgroundRow,
	input logic [statusWidth-1:0] livesCode,
	input logic [levelWidth-1:0] levelCode,
	output logic [displayWidth-1:0] displayCode,
	output logic [modeWidth-1:0] pieceMode,
	output logic [rowWidth-1:0] rowData,
	output logic lifeStrobe,
	output logic [levelWidth-1:0] levelLoad,
	output logic gameReset
);

	eventKind_t eventKind;
	eventSlot_u eventSlot;
	eventSlot_u heldSlot;
	gameState_t state;
	logic [rowWidth-1:0] mergedRow;
	logic [1:0] cursor;
	logic levelPick;
	logic menuOpen;
	logic menuActive;

	// Datapath status bundle
	boardEventIf board ();
	assign board.crashCode = crashCode;
	assign board.livesCode = livesCode;
	assign board.levelCode = levelCode;
	assign board.pointRow = pointRow;
	assign board.backgroundRow = backgroundRow;

	boardEventDecoder eventDecoder (
		.board(board.decoder),
		.eventKind(eventKind),
		.eventSlot(eventSlot),
		.mergedRow(mergedRow)
	);

	levelMenu menuUnit (
		.SC_STATEMACHINEMAIN_CLOCK_50(SC_STATEMACHINEMAIN_CLOCK_50),
		.SC_STATEMACHINEMAIN_RESET_InHigh(SC_STATEMACHINEMAIN_RESET_InHigh),
		.menuOpen(menuOpen),
		.menuActive(menuActive),
		.startButtonLow(startButtonLow),
		.leftButtonLow(leftButtonLow),
		.rightButtonLow(rightButtonLow),
		.cursor(cursor),
		.levelPick(levelPick)
	);

	gameSequencer sequencer (
		.SC_STATEMACHINEMAIN_CLOCK_50(SC_STATEMACHINEMAIN_CLOCK_50),
		.SC_STATEMACHINEMAIN_RESET_InHigh(SC_STATEMACHINEMAIN_RESET_InHigh),
		.startButtonLow(startButtonLow),
		.finishLow(finishLow),
		.levelPick(levelPick),
		.eventKind(eventKind),
		.eventSlot(eventSlot),
		.state(state),
		.heldSlot(heldSlot),
		.menuOpen(menuOpen),
		.menuActive(menuActive)
	);

	screenOutputDecoder screenDecoder (
		.state(state),
		.heldSlot(heldSlot),
		.cursor(cursor),
		.mergedRow(mergedRow),
		.board(board.screen),
		.displayCode(displayCode),
		.pieceMode(pieceMode),
		.rowData(rowData),
		.lifeStrobe(lifeStrobe),
		.levelLoad(levelLoad),
		.gameReset(gameReset)
	);

endmodule

// ==== hdl/gamePkg.sv ====
package gamePkg;

	// ============================================================
	// Widths
	// ============================================================
	// One matrix row
	localparam int rowWidth = 8;
	localparam int displayWidth = 4;
	localparam int modeWidth = 2;
	localparam int levelWidth = 3;
	// Crash and lives codes from the datapath
	localparam int statusWidth = 2;

	// ============================================================
	// State encoding
	// ============================================================
	typedef enum logic [4:0] {
		reset0, reset1, idle, menu, levelLoad,
		start0, start1, start2, check,
		crashShow, crashWait, winLifeShow, winLifeWait,
		rowFlash, rowSettle, levelShow, levelWait
	} gameState_t;

	// Board event classes
	typedef enum logic [2:0] {
		evNone, evCrash, evLastCrash, evWinLife,
		evRowFull, evLevelClear, evGameWon
	} eventKind_t;

	// Lives left on a crash, level index on a full row
	typedef union packed {
		logic [1:0] livesLeft;
		logic [1:0] levelIndex;
	} eventSlot_u;

	// Display codes
	localparam logic [displayWidth-1:0] showClear = 4'b0110;
	localparam logic [displayWidth-1:0] showBlank = 4'b0000;
	localparam logic [displayWidth-1:0] showCursor0 = 4'b1100;
	localparam logic [displayWidth-1:0] showCursor1 = 4'b1101;
	localparam logic [displayWidth-1:0] showCursor2 = 4'b1110;
	localparam logic [displayWidth-1:0] showCursor3 = 4'b1111;
	localparam logic [displayWidth-1:0] showStart = 4'b0001;
	localparam logic [displayWidth-1:0] showCrash3 = 4'b1000;
	localparam logic [displayWidth-1:0] showCrash2 = 4'b1001;
	localparam logic [displayWidth-1:0] showCrash1 = 4'b1010;
	localparam logic [displayWidth-1:0] showWinLife = 4'b1011;
	localparam logic [displayWidth-1:0] showLevel1 = 4'b0010;
	localparam logic [displayWidth-1:0] showLevel2 = 4'b0011;
	localparam logic [displayWidth-1:0] showLevel3 = 4'b0100;
	localparam logic [displayWidth-1:0] showWon = 4'b0111;

	// Piece modes
	localparam logic [modeWidth-1:0] modeRun = 2'b00;
	localparam logic [modeWidth-1:0] modeLoad = 2'b01;
	localparam logic [modeWidth-1:0] modeHold = 2'b10;

	// Level load codes
	localparam logic [levelWidth-1:0] levelIdle = 3'b111;
	localparam logic [levelWidth-1:0] levelCleared = 3'b000;

	// Start rows, one per level
	localparam logic [rowWidth-1:0] levelPattern [4] = '{
		8'b11101111, 8'b11100111, 8'b10101101, 8'b10100101
	};

endpackage

// ==== hdl/gameSequencer.sv ====
module gameSequencer
	import gamePkg::*;
(
	input logic SC_STATEMACHINEMAIN_CLOCK_50,
	input logic SC_STATEMACHINEMAIN_RESET_InHigh,
	input logic startButtonLow,
	input logic finishLow,
	input logic levelPick,
	input eventKind_t eventKind,
	input eventSlot_u eventSlot,
	output gameState_t state,
	output eventSlot_u heldSlot,
	output logic menuOpen,
	output logic menuActive
);

	gameState_t nextState;

	// Menu handshake
	assign menuOpen = (state == idle) && !startButtonLow;
	assign menuActive = (state == menu);

	// ============================================================
	// Next state
	// ============================================================
	always_comb
	begin
		nextState = state;
		case (state)
			// Board clear
			reset0: nextState = reset1;
			reset1: nextState = idle;
			idle:
			begin
				if (!startButtonLow)
					nextState = menu;
				else if (finishLow)
					nextState = start0;
			end
			menu:
			begin
				if (levelPick)
					nextState = levelLoad;
			end
			levelLoad: nextState = check;
			// Direct start on level 1
			start0: nextState = start1;
			start1:
			begin
				if (finishLow)
					nextState = start2;
			end
			start2: nextState = check;
			check:
			begin
				case (eventKind)
					evCrash, evLastCrash: nextState = crashShow;
					evWinLife: nextState = winLifeShow;
					evRowFull: nextState = rowFlash;
					evLevelClear, evGameWon: nextState = levelShow;
					default: nextState = check;
				endcase
			end
			crashShow: nextState = crashWait;
			// Last life ends the game
			crashWait:
			begin
				if (finishLow)
					nextState = (heldSlot.livesLeft == 2'd1) ? reset0 : check;
			end
			winLifeShow: nextState = winLifeWait;
			winLifeWait:
			begin
				if (finishLow)
					nextState = check;
			end
			// Fixed merge, no animation
			rowFlash: nextState = rowSettle;
			rowSettle: nextState = check;
			levelShow: nextState = levelWait;
			// Index 3 is the final level
			levelWait:
			begin
				if (finishLow)
					nextState = (heldSlot.levelIndex == 2'd3) ? reset0 : check;
			end
		endcase
	end

	// State register
	always_ff @(posedge SC_STATEMACHINEMAIN_CLOCK_50, posedge SC_STATEMACHINEMAIN_RESET_InHigh)
	begin
		if (SC_STATEMACHINEMAIN_RESET_InHigh)
			state <= reset0;
		else
			state <= nextState;
	end

	// Slot captured as check leaves for a show state
	always_ff @(posedge SC_STATEMACHINEMAIN_CLOCK_50, posedge SC_STATEMACHINEMAIN_RESET_InHigh)
	begin
		if (SC_STATEMACHINEMAIN_RESET_InHigh)
			heldSlot <= '0;
		else if (state == check && eventKind != evNone)
			heldSlot <= eventSlot;
	end

endmodule

// ==== hdl/levelMenu.sv ====
module levelMenu
	import gamePkg::*;
(
	input logic SC_STATEMACHINEMAIN_CLOCK_50,
	input logic SC_STATEMACHINEMAIN_RESET_InHigh,
	input logic menuOpen,
	input logic menuActive,
	input logic startButtonLow,
	input logic leftButtonLow,
	input logic rightButtonLow,
	output logic [1:0] cursor,
	output logic levelPick
);

	// Set after every move, cleared once all buttons are up
	logic releaseWait;
	logic allReleased;

	assign allReleased = startButtonLow & leftButtonLow & rightButtonLow;

	// Start press, with left and right up and nothing pending
	assign levelPick = menuActive & ~releaseWait & rightButtonLow & leftButtonLow
		& ~startButtonLow;

	// ============================================================
	// Cursor and release tracking
	// ============================================================
	always_ff @(posedge SC_STATEMACHINEMAIN_CLOCK_50, posedge SC_STATEMACHINEMAIN_RESET_InHigh)
	begin
		if (SC_STATEMACHINEMAIN_RESET_InHigh)
		begin
			cursor <= 2'd0;
			releaseWait <= 1'b0;
		end
		else if (menuOpen)
		begin
			// Start button is still down on entry
			cursor <= 2'd0;
			releaseWait <= 1'b1;
		end
		else if (menuActive)
		begin
			if (releaseWait)
			begin
				if (allReleased)
					releaseWait <= 1'b0;
			end
			// Right wins over left
			else if (!rightButtonLow)
			begin
				cursor <= cursor + 2'd1;
				releaseWait <= 1'b1;
			end
			else if (!leftButtonLow)
			begin
				// Wraps from 0 to 3
				cursor <= cursor - 2'd1;
				releaseWait <= 1'b1;
			end
		end
	end

endmodule

// ==== hdl/screenOutputDecoder.sv ====
module screenOutputDecoder
	import gamePkg::*;
(
	input gameState_t state,
	input eventSlot_u heldSlot,
	input logic [1:0] cursor,
	input logic [rowWidth-1:0] mergedRow,
	boardEventIf.screen board,
	output logic [displayWidth-1:0] displayCode,
	output logic [modeWidth-1:0] pieceMode,
	output logic [rowWidth-1:0] rowData,
	output logic lifeStrobe,
	output logic [levelWidth-1:0] levelLoad,
	output logic gameReset
);

	// ============================================================
	// Per-state outputs
	// ============================================================
	always_comb
	begin
		// Piece held over the background
		displayCode = showBlank;
		pieceMode = modeHold;
		rowData = board.backgroundRow;
		lifeStrobe = 1'b1;
		levelLoad = levelIdle;
		gameReset = 1'b0;
		case (state)
			reset0, reset1:
			begin
				displayCode = showClear;
				rowData = '0;
				gameReset = 1'b1;
			end
			idle:
			begin
				rowData = '0;
				gameReset = 1'b1;
			end
			menu:
			begin
				rowData = '0;
				case (cursor)
					2'd0: displayCode = showCursor0;
					2'd1: displayCode = showCursor1;
					2'd2: displayCode = showCursor2;
					default: displayCode = showCursor3;
				endcase
			end
			// Port of the same name hides the state here
			gamePkg::levelLoad:
			begin
				pieceMode = modeLoad;
				rowData = levelPattern[cursor];
				levelLoad = {1'b0, cursor} + 3'd1;
			end
			start0:
			begin
				displayCode = showStart;
				rowData = '0;
			end
			start1: rowData = levelPattern[0];
			start2:
			begin
				pieceMode = modeLoad;
				rowData = levelPattern[0];
			end
			check, rowSettle: pieceMode = modeRun;
			crashShow:
			begin
				lifeStrobe = 1'b0;
				case (heldSlot.livesLeft)
					2'd3: displayCode = showCrash3;
					2'd2: displayCode = showCrash2;
					default: displayCode = showCrash1;
				endcase
			end
			winLifeShow:
			begin
				displayCode = showWinLife;
				lifeStrobe = 1'b0;
			end
			// Merged row written back to the board
			rowFlash:
			begin
				pieceMode = modeLoad;
				rowData = mergedRow;
			end
			levelShow:
			begin
				levelLoad = levelCleared;
				if (heldSlot.levelIndex == 2'd3)
					displayCode = showWon;
				else
				begin
					// Start row of the next level
					rowData = levelPattern[heldSlot.levelIndex + 2'd1];
					case (heldSlot.levelIndex)
						2'd0: displayCode = showLevel1;
						2'd1: displayCode = showLevel2;
						default: displayCode = showLevel3;
					endcase
				end
			end
			crashWait, winLifeWait, levelWait: displayCode = showBlank;
		endcase
	end

endmodule

// ==== verif/gameMainControlTb.sv ====
module gameMainControlTb;

	timeunit 1ns;
	timeprecision 1ps;

	// Model states, in game flow order
	typedef enum int {
		sReset0, sReset1, sIdle, sMenu, sLevelLoad, sStart0, sStart1, sStart2, sCheck,
		sCrashShow, sCrashWait, sLifeShow, sLifeWait, sRowFlash, sRowSettle,
		sLevelShow, sLevelWait
	} modelState_t;

	// Board event classes
	typedef enum int {
		kNone, kCrash, kLastCrash, kWinLife, kRowFull, kLevelClear, kGameWon
	} modelKind_t;

	logic SC_STATEMACHINEMAIN_CLOCK_50;
	logic SC_STATEMACHINEMAIN_RESET_InHigh;
	logic startButtonLow;
	logic leftButtonLow;
	logic rightButtonLow;
	logic finishLow;
	logic [1:0] crashCode;
	logic [7:0] pointRow;
	logic [7:0] backgroundRow;
	logic [1:0] livesCode;
	logic [2:0] levelCode;
	logic [3:0] displayCode;
	logic [1:0] pieceMode;
	logic [7:0] rowData;
	logic lifeStrobe;
	logic [2:0] levelLoad;
	logic gameReset;

	// Reference model registers
	modelState_t modelState;
	modelKind_t modelKind;
	logic [1:0] modelSlot;
	logic [1:0] modelCursor;
	logic modelWait;

	integer seed;
	logic [31:0] randomWord;

	gameMainControl UUT (.*);

	// 4 ns clock
	initial
	begin
		SC_STATEMACHINEMAIN_CLOCK_50 = 1'b0;
		forever
			#2 SC_STATEMACHINEMAIN_CLOCK_50 = ~SC_STATEMACHINEMAIN_CLOCK_50;
	end

	// ============================================================
	// Reference model
	// ============================================================
	// Start row of each level
	function automatic logic [7:0] startRow(input logic [1:0] index);
		case (index)
			2'd0: return 8'b11101111;
			2'd1: return 8'b11100111;
			2'd2: return 8'b10101101;
			default: return 8'b10100101;
		endcase
	endfunction

	// Slot is lives left for crashes, level minus one for full rows
	function automatic modelKind_t classifyEvent(input logic [1:0] crash,
		input logic [1:0] lives, input logic [2:0] level, input logic [7:0] merged,
		output logic [1:0] slot);
		slot = lives;
		if (crash == 2'b01 && (lives == 2'd3 || lives == 2'd2))
			return kCrash;
		if (crash == 2'b01 && lives == 2'd1)
			return kLastCrash;
		if (crash == 2'b11 && lives == 2'd1)
			return kWinLife;
		if (crash == 2'b10 && merged != 8'hff)
			return kRowFull;
		slot = level[1:0] - 2'd1;
		if (crash == 2'b10 && level >= 3'd1 && level <= 3'd3)
			return kLevelClear;
		if (crash == 2'b10 && level == 3'd4)
			return kGameWon;
		return kNone;
	endfunction

	// Packed as display, mode, row, strobe, level load, game reset
	function automatic logic [18:0] expectedOutputs(input modelState_t st,
		input logic [1:0] cursor, input modelKind_t kind, input logic [1:0] slot,
		input logic [7:0] background, input logic [7:0] merged);
		case (st)
			sReset0, sReset1: return {4'b0110, 2'b10, 8'h00, 1'b1, 3'b111, 1'b1};
			sIdle: return {4'b0000, 2'b10, 8'h00, 1'b1, 3'b111, 1'b1};
			sMenu: return {2'b11, cursor, 2'b10, 8'h00, 1'b1, 3'b111, 1'b0};
			// Level number is cursor plus one
			sLevelLoad:
				return {4'b0000, 2'b01, startRow(cursor), 1'b1, {1'b0, cursor} + 3'd1, 1'b0};
			sStart0: return {4'b0001, 2'b10, 8'h00, 1'b1, 3'b111, 1'b0};
			sStart1: return {4'b0000, 2'b10, startRow(2'd0), 1'b1, 3'b111, 1'b0};
			sStart2: return {4'b0000, 2'b01, startRow(2'd0), 1'b1, 3'b111, 1'b0};
			sCheck, sRowSettle: return {4'b0000, 2'b00, background, 1'b1, 3'b111, 1'b0};
			// 3, 2, 1 lives give 1000, 1001, 1010
			sCrashShow: return {2'b10, 2'd3 - slot, 2'b10, background, 1'b0, 3'b111, 1'b0};
			sLifeShow: return {4'b1011, 2'b10, background, 1'b0, 3'b111, 1'b0};
			sRowFlash: return {4'b0000, 2'b01, merged, 1'b1, 3'b111, 1'b0};
			sLevelShow:
				return (kind == kGameWon) ? {4'b0111, 2'b10, background, 1'b1, 3'b000, 1'b0}
					: {{2'b00, slot} + 4'd2, 2'b10, startRow(slot + 2'd1), 1'b1, 3'b000, 1'b0};
			// Wait states
			default: return {4'b0000, 2'b10, background, 1'b1, 3'b111, 1'b0};
		endcase
	endfunction

	// One clock edge of the model
	task automatic advanceModel();
		modelState_t next;
		modelKind_t kind;
		logic [1:0] slot;
		logic pick;
		kind = classifyEvent(crashCode, livesCode, levelCode, pointRow | backgroundRow, slot);
		// Start alone, nothing pending
		pick = (modelState == sMenu) && !modelWait && !startButtonLow && leftButtonLow
			&& rightButtonLow;
		next = modelState;
		case (modelState)
			sReset0: next = sReset1;
			sReset1: next = sIdle;
			sIdle: next = !startButtonLow ? sMenu : (finishLow ? sStart0 : sIdle);
			sMenu: next = pick ? sLevelLoad : sMenu;
			sLevelLoad, sStart2, sRowSettle: next = sCheck;
			sStart0: next = sStart1;
			sStart1: next = finishLow ? sStart2 : sStart1;
			sCrashShow: next = sCrashWait;
			sLifeShow: next = sLifeWait;
			sRowFlash: next = sRowSettle;
			sLevelShow: next = sLevelWait;
			sLifeWait: next = finishLow ? sCheck : sLifeWait;
			// Last life and last level end the game
			sCrashWait: next = !finishLow ? sCrashWait : (modelKind == kLastCrash ? sReset0 : sCheck);
			sLevelWait: next = !finishLow ? sLevelWait : (modelKind == kGameWon ? sReset0 : sCheck);
			sCheck:
			begin
				if (kind != kNone)
				begin
					modelKind = kind;
					modelSlot = slot;
				end
				case (kind)
					kCrash, kLastCrash: next = sCrashShow;
					kWinLife: next = sLifeShow;
					kRowFull: next = sRowFlash;
					kLevelClear, kGameWon: next = sLevelShow;
					default: next = sCheck;
				endcase
			end
			default: next = modelState;
		endcase
		// Cursor steps once per press
		if (modelState == sIdle && !startButtonLow)
		begin
			modelCursor = 2'd0;
			modelWait = 1'b1;
		end
		else if (modelState == sMenu && modelWait)
			modelWait = !(startButtonLow && leftButtonLow && rightButtonLow);
		else if (modelState == sMenu && !rightButtonLow)
		begin
			modelCursor = modelCursor + 2'd1;
			modelWait = 1'b1;
		end
		else if (modelState == sMenu && !leftButtonLow)
		begin
			modelCursor = modelCursor - 2'd1;
			modelWait = 1'b1;
		end
		modelState = next;
	endtask

	task automatic checkValue(input logic [18:0] got, input logic [18:0] expected);
		if (got !== expected)
		begin
			$display("FAILED at %0t ns: display,mode,row,strobe,level,reset %b expected %b",
				$time, got, expected);
			$display("TESTBENCH FAILED");
			$fatal(1, "Output mismatch");
		end
	endtask

	// Outputs of the current state against the model, then one model step
	always @(posedge SC_STATEMACHINEMAIN_CLOCK_50)
	begin
		if (SC_STATEMACHINEMAIN_RESET_InHigh)
		begin
			modelState = sReset0;
			modelCursor = 2'd0;
			modelWait = 1'b0;
		end
		checkValue({displayCode, pieceMode, rowData, lifeStrobe, levelLoad, gameReset},
			expectedOutputs(modelState, modelCursor, modelKind, modelSlot, backgroundRow,
			pointRow | backgroundRow));
		if (!SC_STATEMACHINEMAIN_RESET_InHigh)
			advanceModel();
	end

	// ============================================================
	// Stimulus
	// ============================================================
	task automatic randomRows();
		logic [31:0] bits;
		bits = $random(seed);
		pointRow = bits[7:0];
		backgroundRow = bits[15:8];
	endtask

	task automatic setButtons(input logic start, input logic left, input logic right,
		input int cycles);
		repeat (cycles)
		begin
			@(negedge SC_STATEMACHINEMAIN_CLOCK_50);
			startButtonLow = start;
			leftButtonLow = left;
			rightButtonLow = right;
			randomRows();
		end
	endtask

	// Animation finish mostly low, so waits stretch
	task automatic reachState(input modelState_t target, input int limit);
		int count;
		logic [31:0] bits;
		count = 0;
		while (modelState != target && count < limit)
		begin
			@(negedge SC_STATEMACHINEMAIN_CLOCK_50);
			bits = $random(seed);
			crashCode = 2'b00;
			finishLow = (bits[1:0] == 2'b00);
			randomRows();
			count++;
		end
		if (modelState != target)
		begin
			$display("TESTBENCH FAILED");
			$fatal(1, "Timed out waiting for state %s", target.name());
		end
	endtask

	// One cycle of board status from check, then back to check
	task automatic fireEvent(input logic [1:0] crash, input logic [1:0] lives,
		input logic [2:0] level, input logic [7:0] point, input logic [7:0] background);
		@(negedge SC_STATEMACHINEMAIN_CLOCK_50);
		crashCode = crash;
		livesCode = lives;
		levelCode = level;
		pointRow = point;
		backgroundRow = background;
		finishLow = 1'b0;
		@(negedge SC_STATEMACHINEMAIN_CLOCK_50);
		crashCode = 2'b00;
		reachState(sCheck, 100);
	endtask

	initial
	begin
		seed = 32'h5f7b;
		SC_STATEMACHINEMAIN_RESET_InHigh = 1'b0;
		startButtonLow = 1'b1;
		leftButtonLow = 1'b1;
		rightButtonLow = 1'b1;
		finishLow = 1'b0;
		crashCode = 2'b00;
		livesCode = 2'd3;
		levelCode = 3'd1;
		pointRow = 8'h00;
		backgroundRow = 8'h00;
		modelState = sReset0;
		modelKind = kNone;
		modelSlot = 2'd0;
		modelCursor = 2'd0;
		modelWait = 1'b0;
		#1 SC_STATEMACHINEMAIN_RESET_InHigh = 1'b1;
		repeat (4) @(negedge SC_STATEMACHINEMAIN_CLOCK_50);
		SC_STATEMACHINEMAIN_RESET_InHigh = 1'b0;
		// Board clear then idle, held by finish low
		setButtons(1'b1, 1'b1, 1'b1, 6);
		// Menu entry with start still held
		setButtons(1'b0, 1'b1, 1'b1, 3);
		setButtons(1'b1, 1'b1, 1'b1, 1);
		// Held presses of random length
		repeat (12)
		begin
			randomWord = $random(seed);
			if (randomWord[2])
				setButtons(1'b1, 1'b1, 1'b0, 1 + randomWord[1:0]);
			else
				setButtons(1'b1, 1'b0, 1'b1, 1 + randomWord[1:0]);
			setButtons(1'b1, 1'b1, 1'b1, 1 + randomWord[3]);
		end
		// Pick a level
		setButtons(1'b0, 1'b1, 1'b1, 1);
		setButtons(1'b1, 1'b1, 1'b1, 1);
		reachState(sCheck, 10);
		// Crashes, bonus life, ignored crash
		fireEvent(2'b01, 2'd3, 3'd1, 8'h00, 8'h5a);
		fireEvent(2'b01, 2'd2, 3'd1, 8'h00, 8'h5a);
		fireEvent(2'b11, 2'd1, 3'd1, 8'h00, 8'h5a);
		fireEvent(2'b01, 2'd0, 3'd1, 8'h00, 8'h5a);
		// Merge short of a full row
		fireEvent(2'b10, 2'd1, 3'd2, 8'h0c, 8'h30);
		// Full rows on levels 1 to 3
		fireEvent(2'b10, 2'd2, 3'd1, 8'h0f, 8'hf0);
		fireEvent(2'b10, 2'd2, 3'd2, 8'h0f, 8'hf0);
		fireEvent(2'b10, 2'd2, 3'd3, 8'h0f, 8'hf0);
		// Last life, then a direct start from idle
		fireEvent(2'b01, 2'd1, 3'd1, 8'h00, 8'h81);
		// Final level, reset, direct start again
		fireEvent(2'b10, 2'd2, 3'd4, 8'hff, 8'h00);
		// Free-running random inputs, buttons mostly up
		repeat (4000)
		begin
			@(negedge SC_STATEMACHINEMAIN_CLOCK_50);
			randomWord = $random(seed);
			startButtonLow = (randomWord[2:0] != 3'b000);
			leftButtonLow = (randomWord[5:3] != 3'b000);
			rightButtonLow = (randomWord[8:6] != 3'b000);
			finishLow = randomWord[9];
			crashCode = randomWord[11:10];
			livesCode = randomWord[13:12];
			levelCode = randomWord[16:14];
			randomRows();
			// Some full merged rows
			if (randomWord[18:17] == 2'b00)
				pointRow = ~backgroundRow;
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule
